// ==== verilog/aluPkg.sv ====
/*
  Shared ALU types: opcodes, Wishbone word addresses and compare flags.
  Opcodes 10 to 15 are illegal and give a zero result.
*/
package aluPkg;

  // ALU operation codes as written to REG_OP
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_SLL  = 4'd2,
    OP_SLT  = 4'd3,
    OP_SLTU = 4'd4,
    OP_XOR  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_OR   = 4'd8,
    OP_AND  = 4'd9
  } aluOpT;

  // word addresses on the bus
  typedef enum logic [2:0] {
    REG_A      = 3'd0,
    REG_B      = 3'd1,
    REG_OP     = 3'd2,
    REG_RESULT = 3'd3, // read only
    REG_FLAGS  = 3'd4  // read only
  } regAddrT;

  // compare of A against B, independent of opcode
  typedef struct packed {
    logic eq;  // bit 2
    logic lt;  // signed, bit 1
    logic ltu; // unsigned, bit 0
  } aluFlagsT;

endpackage

// ==== verilog/aluCtrlIf.sv ====
/*
  Operand, opcode, result and flag bundle between register block and core.
  WIDTH must match the modules on both sides.
*/
`timescale 1ns/1ps

interface aluCtrlIf import aluPkg::*; #(
  parameter int WIDTH = 32
);

  logic [WIDTH-1:0] opA;
  logic [WIDTH-1:0] opB;
  aluOpT            op;
  logic [WIDTH-1:0] result;
  aluFlagsT         flags;

  // register side owns operands and opcode
  modport regs (output opA, opB, op, input result, flags);

  // core side computes result and flags
  modport core (input opA, opB, op, output result, flags);

endinterface

// ==== verilog/funnelShifter.sv ====
/*
  Funnel shifter for sll, srl and sra. WIDTH must be a power of two,
  shift amount is taken modulo WIDTH.
*/
`timescale 1ns/1ps

module funnelShifter #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]         a,
  input  logic [$clog2(WIDTH)-1:0] amt,
  input  logic                     right,
  input  logic                     arith,
  output logic [WIDTH-1:0]         y
);

  logic [2*WIDTH-2:0]       funnel;
  logic [2*WIDTH-2:0]       funnelShift;
  logic [$clog2(WIDTH)-1:0] offset;
  logic                     fillBit;

  assign fillBit = arith & a[WIDTH-1]; // sign copies for sra only

  // left: operand at the top, zeros below
  // right: operand at the bottom, fill above
  always_comb begin
    if (right) begin
      funnel = {{(WIDTH-1){fillBit}}, a};
    end else begin
      funnel = {a, {(WIDTH-1){1'b0}}};
    end
  end

  // inverted amount gives WIDTH-1-amt for left shifts
  assign offset = right ? amt : ~amt;

  assign funnelShift = funnel >> offset;
  assign y           = funnelShift[WIDTH-1:0];

endmodule

// ==== verilog/aluCore.sv ====
/*
  Combinational integer ALU. Flags always compare opA with opB,
  whatever the opcode. Illegal opcodes give a zero result.
*/
`timescale 1ns/1ps

module aluCore import aluPkg::*; #(
  parameter int WIDTH = 32
) (
  aluCtrlIf.core ctrl
);

  localparam int AMTW = $clog2(WIDTH);

  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  logic [WIDTH-1:0] condInvB;
  logic [WIDTH-1:0] sum;
  logic [WIDTH-1:0] shiftY;
  logic [WIDTH-1:0] aFlip;
  logic [WIDTH-1:0] bFlip;
  logic [WIDTH-1:0] result;
  logic             subArith;
  logic             right;
  logic             arith;
  logic             isEq;
  logic             isLt;
  logic             isLtu;

  assign a = ctrl.opA;
  assign b = ctrl.opB;

  // subtract path: invert B, carry in one
  assign subArith = (ctrl.op == OP_SUB) | (ctrl.op == OP_SLT) | (ctrl.op == OP_SLTU);
  assign condInvB = subArith ? ~b : b;
  assign sum      = a + condInvB + {{(WIDTH-1){1'b0}}, subArith};

  // flipping the sign bits turns a signed compare into an unsigned one
  assign aFlip = {~a[WIDTH-1], a[WIDTH-2:0]};
  assign bFlip = {~b[WIDTH-1], b[WIDTH-2:0]};
  assign isEq  = (aFlip == bFlip);
  assign isLt  = (aFlip < bFlip);
  assign isLtu = (a < b); // plain unsigned

  assign right = (ctrl.op == OP_SRL) | (ctrl.op == OP_SRA);
  assign arith = (ctrl.op == OP_SRA);

  funnelShifter #(.WIDTH(WIDTH)) sh0 (
    .a     (a),
    .amt   (b[AMTW-1:0]), // low bits of B only
    .right (right),
    .arith (arith),
    .y     (shiftY)
  );

  always_comb begin
    case (ctrl.op)
      OP_ADD, OP_SUB:         result = sum;
      OP_SLL, OP_SRL, OP_SRA: result = shiftY;
      OP_SLT:                 result = {{(WIDTH-1){1'b0}}, isLt};
      OP_SLTU:                result = {{(WIDTH-1){1'b0}}, isLtu};
      OP_XOR:                 result = a ^ b;
      OP_OR:                  result = a | b;
      OP_AND:                 result = a & b;
      default:                result = '0; // codes 10..15
    endcase
  end

  assign ctrl.result = result;
  assign ctrl.flags  = '{eq: isEq, lt: isLt, ltu: isLtu};

endmodule

// ==== verilog/aluRegs.sv ====
/*
  Wishbone classic slave for the ALU accelerator. Full-word writes only,
  no err/rty, no pipelined mode. Ack comes one cycle after the request.
  Writes to read-only or unused addresses are acked and dropped.
*/
`timescale 1ns/1ps

module aluRegs import aluPkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             wbCyc,
  input  logic             wbStb,
  input  logic             wbWe,
  input  logic [2:0]       wbAdr,
  input  logic [WIDTH-1:0] wbDatW,
  output logic [WIDTH-1:0] wbDatR,
  output logic             wbAck,
  aluCtrlIf.regs           ctrl
);

  logic [WIDTH-1:0] regA;
  logic [WIDTH-1:0] regB;
  aluOpT            regOp;
  regAddrT          addr;
  logic             request;
  logic             wrEn;
  logic             rdEn;
  logic [WIDTH-1:0] rdData;

  assign addr    = regAddrT'(wbAdr);
  assign request = wbCyc & wbStb & ~wbAck; // new access, not the acked one
  assign wrEn    = request & wbWe;
  assign rdEn    = request & ~wbWe;

  // single-cycle ack, drops on the following edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= request;
    end
  end

  // operand and opcode registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regA  <= '0;
      regB  <= '0;
      regOp <= OP_ADD;
    end else if (wrEn) begin
      case (addr)
        REG_A:   regA  <= wbDatW;
        REG_B:   regB  <= wbDatW;
        REG_OP:  regOp <= aluOpT'(wbDatW[3:0]); // illegal codes kept as written
        default: ;                              // result, flags, unused
      endcase
    end
  end

  // read select
  always_comb begin
    case (addr)
      REG_A:      rdData = regA;
      REG_B:      rdData = regB;
      REG_OP:     rdData = {{(WIDTH-4){1'b0}}, regOp};
      REG_RESULT: rdData = ctrl.result;
      REG_FLAGS:  rdData = {{(WIDTH-3){1'b0}}, ctrl.flags};
      default:    rdData = '0;
    endcase
  end

  // read data captured with the ack
  always_ff @(posedge clk) begin
    if (rdEn) begin
      wbDatR <= rdData;
    end
  end

  assign ctrl.opA = regA;
  assign ctrl.opB = regB;
  assign ctrl.op  = regOp;

endmodule

// ==== verilog/aluAccelTop.sv ====
/*
  ALU accelerator on a Wishbone classic bus, word addressed (3-bit wbAdr).
  WIDTH is a power of two from 8 to 64. Every access acks after one cycle.
*/
`timescale 1ns/1ps

module aluAccelTop #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             wbCyc,
  input  logic             wbStb,
  input  logic             wbWe,
  input  logic [2:0]       wbAdr,
  input  logic [WIDTH-1:0] wbDatW,
  output logic [WIDTH-1:0] wbDatR,
  output logic             wbAck
);

  aluCtrlIf #(.WIDTH(WIDTH)) ctrl0 ();

  // bus slave and operand registers
  aluRegs #(.WIDTH(WIDTH)) regs0 (
    .clk    (clk),
    .reset  (reset),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck),
    .ctrl   (ctrl0)
  );

  // combinational datapath
  aluCore #(.WIDTH(WIDTH)) core0 (
    .ctrl (ctrl0)
  );

endmodule

// ==== dv/aluAccel_sva.sv ====
/*
  Bound Wishbone checks for aluAccelTop. Each request gets exactly one ack
  on the next cycle, and ack stays low while reset is high.
*/
`timescale 1ns/1ps

module aluAccelSva (
  input logic clk,
  input logic reset,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck
);

  logic request;

  assign request = wbCyc & wbStb & ~wbAck;

  // every ack answers a request one edge earlier
  ackFollowsRequest: assert property (
    @(posedge clk) disable iff (reset) wbAck |-> $past(request)
  ) else $error("ack without a request on the previous cycle");

  requestAcked: assert property (
    @(posedge clk) disable iff (reset) request |=> wbAck
  ) else $error("request not acked on the next cycle");

  singleAck: assert property (
    @(posedge clk) disable iff (reset) wbAck |=> !wbAck
  ) else $error("ack high on two cycles in a row");

  noAckInReset: assert property (@(posedge clk) reset |-> !wbAck)
    else $error("ack high during reset");

endmodule

bind aluAccelTop aluAccelSva sva0 (
  .clk   (clk),
  .reset (reset),
  .wbCyc (wbCyc),
  .wbStb (wbStb),
  .wbAck (wbAck)
);

// ==== dv/aluAccelTb.sv ====
/*
  Directed and random testbench for the ALU accelerator at WIDTH 32.
  Single bus accesses only with one idle cycle between them.
*/
`timescale 1ns/1ps

module aluAccelTb import aluPkg::*; ();

  localparam int WIDTH       = 32;
  localparam int AMTW        = $clog2(WIDTH);
  localparam int ACK_TIMEOUT = 20; // cycles

  logic             clk;
  logic             reset;
  logic             wbCyc;
  logic             wbStb;
  logic             wbWe;
  logic [2:0]       wbAdr;
  logic [WIDTH-1:0] wbDatW;
  logic [WIDTH-1:0] wbDatR;
  logic             wbAck;
  int               seed;
  string            opNames [10] = '{"add", "sub", "sll", "slt", "sltu",
                                     "xor", "srl", "sra", "or", "and"};

  aluAccelTop #(.WIDTH(WIDTH)) dut0 (
    .clk    (clk),
    .reset  (reset),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  always #50 clk = ~clk;

  // expected result straight from the opcode table
  function automatic logic [WIDTH-1:0] aluModel(input logic [3:0] op,
                                                input logic [WIDTH-1:0] a,
                                                input logic [WIDTH-1:0] b);
    logic [AMTW-1:0] amt;
    amt = b[AMTW-1:0];
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_SLL:  return a << amt;
      OP_SLT:  return {{(WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
      OP_SLTU: return {{(WIDTH-1){1'b0}}, a < b};
      OP_XOR:  return a ^ b;
      OP_SRL:  return a >> amt;
      OP_SRA:  return $signed(a) >>> amt;
      OP_OR:   return a | b;
      OP_AND:  return a & b;
      default: return '0;
    endcase
  endfunction

  // eq, lt, ltu zero-extended
  function automatic logic [WIDTH-1:0] compareFlags(input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b);
    return {{(WIDTH-3){1'b0}}, a == b, $signed(a) < $signed(b), a < b};
  endfunction

  task automatic checkValue(input string name, input logic [WIDTH-1:0] exp,
                            input logic [WIDTH-1:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // one access started 1 ns after a rising edge
  task automatic busCycle(input logic we, input logic [2:0] adr,
                          input logic [WIDTH-1:0] dat, output logic [WIDTH-1:0] rd);
    int cycles;
    cycles = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = dat;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!wbAck && cycles < ACK_TIMEOUT);
    if (!wbAck) begin
      $display("TEST FAILED");
      $fatal(1, "no ack within %0d cycles for address %0d", ACK_TIMEOUT, adr);
    end
    assert (cycles == 1) else begin
      $display("[ERROR] ack latency expected 1 actual %0d", cycles);
      $display("TEST FAILED");
      $fatal(1, "wrong ack latency");
    end
    rd    = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
    @(posedge clk); // idle cycle so the next request is a fresh one
    #1;
  endtask

  task automatic writeReg(input logic [2:0] adr, input logic [WIDTH-1:0] dat);
    logic [WIDTH-1:0] unused;
    busCycle(1'b1, adr, dat, unused);
  endtask

  task automatic readReg(input logic [2:0] adr, output logic [WIDTH-1:0] rd);
    busCycle(1'b0, adr, '0, rd);
  endtask

  task automatic runOp(input string name, input logic [3:0] op,
                       input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    logic [WIDTH-1:0] rd;
    writeReg(REG_A, a);
    writeReg(REG_B, b);
    writeReg(REG_OP, {{(WIDTH-4){1'b0}}, op});
    readReg(REG_RESULT, rd);
    checkValue(name, aluModel(op, a, b), rd);
    readReg(REG_FLAGS, rd);
    checkValue({name, " flags"}, compareFlags(a, b), rd);
  endtask

  initial begin : main
    logic [WIDTH-1:0] rd;
    logic [WIDTH-1:0] corners [5];
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [31:0]      rnd;
    logic [3:0]       op;
    clk    = 1'b0;
    reset  = 1'b1;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    seed   = 32'h2d8d_e952;
    corners[0] = 32'h0000_0000;
    corners[1] = 32'hffff_ffff;
    corners[2] = 32'h8000_0000;
    corners[3] = 32'h7fff_ffff;
    corners[4] = 32'h0000_0001;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    readReg(REG_A, rd);
    checkValue("reset A", '0, rd);
    readReg(REG_B, rd);
    checkValue("reset B", '0, rd);
    readReg(REG_OP, rd);
    checkValue("reset OP", '0, rd);
    readReg(REG_RESULT, rd);
    checkValue("reset result", '0, rd);
    readReg(REG_FLAGS, rd);
    checkValue("reset flags", 32'h4, rd); // eq only

    // read-only and unused addresses must not disturb the operands
    writeReg(REG_A, 32'h1234_5678);
    writeReg(REG_B, 32'hdead_beef);
    writeReg(REG_OP, {{(WIDTH-4){1'b0}}, OP_XOR});
    writeReg(REG_RESULT, '1);
    writeReg(REG_FLAGS, '1);
    writeReg(3'd5, '1);
    writeReg(3'd7, '1);
    readReg(REG_A, rd);
    checkValue("readback A", 32'h1234_5678, rd);
    readReg(REG_B, rd);
    checkValue("readback B", 32'hdead_beef, rd);
    readReg(REG_OP, rd);
    checkValue("readback OP", {{(WIDTH-4){1'b0}}, OP_XOR}, rd);
    readReg(REG_RESULT, rd);
    checkValue("readback result", 32'hcc99_e897, rd);
    readReg(3'd6, rd);
    checkValue("unused address", '0, rd);

    // every opcode over all corner pairs including equal and mixed sign
    for (int o = 0; o < 10; o++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          runOp({"corner ", opNames[o]}, 4'(o), corners[i], corners[j]);
        end
      end
    end

    // shift amounts 0, 1, 31 and random with junk above the amount field
    for (int k = 0; k < 12; k++) begin
      a   = (k < 4) ? 32'h8000_00f1 : 32'h7654_3210;
      b   = $random(seed);
      rnd = $random(seed);
      if (k >= 8) a = rnd;
      case (k % 4)
        0:       b[AMTW-1:0] = '0;
        1:       b[AMTW-1:0] = 1;
        2:       b[AMTW-1:0] = AMTW'(WIDTH-1);
        default: ;
      endcase
      runOp("shift sll", OP_SLL, a, b);
      runOp("shift srl", OP_SRL, a, b);
      runOp("shift sra", OP_SRA, a, b);
    end

    runOp("illegal op 12", 4'd12, 32'h1234_5678, 32'h0000_0042);
    runOp("illegal op 15", 4'd15, 32'hffff_ffff, 32'hffff_ffff);

    for (int i = 0; i < 200; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      rnd = $random(seed);
      op  = 4'(rnd[7:0] % 8'd10);
      if (i % 8 == 0) b = a; // equal operands now and then
      runOp({"random ", opNames[op]}, op, a, b);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== aluAccel.f ====
verilog/aluPkg.sv
verilog/aluCtrlIf.sv
verilog/funnelShifter.sv
verilog/aluCore.sv
verilog/aluRegs.sv
verilog/aluAccelTop.sv
dv/aluAccel_sva.sv
dv/aluAccelTb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the ALU accelerator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module aluAccelTb -f aluAccel.f || exit 1
out=$(./obj_dir/ValuAccelTb)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && echo "run ok" || { echo "run failed"; exit 1; }
